/* rtl/rtc_pkg.sv */
`default_nettype none

package rtc_pkg;

  typedef logic [3:0]  bcd_digit_t;
  // hh:mm:ss, seconds in the low digits
  typedef logic [23:0] bcd_time_t;
  // yyyy-mm-dd, day in the low byte
  typedef logic [31:0] bcd_date_t;
  typedef logic [2:0]  dow_t;
  typedef logic [3:0]  axil_addr_t;

  // Clock cycles per second
  localparam logic [31:0] TICK_DIV_DEFAULT = 32'd23_000_000;

  // Register map
  localparam axil_addr_t REG_TIME = 4'h0;
  localparam axil_addr_t REG_DATE = 4'h4;
  localparam axil_addr_t REG_DOW  = 4'h8;
  localparam axil_addr_t REG_CTRL = 4'hC;

  // CTRL bits
  localparam int CTRL_RUN_BIT  = 0;
  localparam int CTRL_LOAD_BIT = 1;
  localparam int CTRL_BUSY_BIT = 2;

  // Digit states first, in the same order as the digits in the counter
  typedef enum logic [4:0] {
    SEC1, SEC10,
    MIN1, MIN10,
    HOUR1, HOUR10,
    DAY1, DAY10,
    MON1, MON10,
    YEAR1, YEAR10, YEAR100, YEAR1000,
    DOW_WAIT,
    LATCH,
    IDLE
  } cal_state_t;

endpackage

`default_nettype wire

/* rtl/rtc_dow_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface rtc_dow_if;

  logic               start;
  rtc_pkg::bcd_date_t date;
  logic               done;
  // Result, 0 is Sunday
  rtc_pkg::dow_t      wday;

  modport cal (
    output start, date,
    input  done, wday
  );

  modport dow (
    input  start, date,
    output done, wday
  );

endinterface

`default_nettype wire

/* rtl/rtc_dow.sv */
`timescale 1ns/100ps
`default_nettype none

module rtc_dow (
  input  logic   clkin,
  input  logic   rst,
  rtc_dow_if.dow port
);

  typedef enum logic [1:0] {
    D_IDLE,
    D_SHIFT,
    D_SUM,
    D_MOD
  } dow_state_t;

  dow_state_t state;
  logic [6:0] day_b;
  logic [6:0] mon_b;
  logic [6:0] yy_b;
  logic [1:0] cc_mod;
  logic [9:0] mon_mult;
  logic [8:0] acc;

  function automatic logic [6:0] bcd2bin(input rtc_pkg::bcd_digit_t tens,
                                         input rtc_pkg::bcd_digit_t ones);
    return {tens, 3'b000} + {2'b00, tens, 1'b0} + {3'b000, ones};
  endfunction

  // 83*m/32 gives the month offset with March as month 1
  assign mon_mult = 10'd83 * {3'b000, mon_b};

  assign port.done = (state == D_MOD) && (acc < 9'd7);
  assign port.wday = acc[2:0];

  always_ff @(posedge clkin) begin
    if (rst) begin
      state <= D_IDLE;
    end else begin
      case (state)
        D_IDLE: begin
          if (port.start) begin
            day_b  <= bcd2bin(port.date[7:4], port.date[3:0]);
            mon_b  <= bcd2bin(port.date[15:12], port.date[11:8]);
            yy_b   <= bcd2bin(port.date[23:20], port.date[19:16]);
            // Century mod 4 is (2*tens + ones) mod 4
            cc_mod <= {port.date[28], 1'b0} + port.date[25:24];
            state  <= D_SHIFT;
          end
        end
        D_SHIFT: begin
          // Jan and Feb count as months 11 and 12 of the year before
          if (mon_b <= 7'd2) begin
            mon_b <= mon_b + 7'd10;
            if (yy_b == 7'd0) begin
              yy_b   <= 7'd99;
              cc_mod <= cc_mod - 2'd1;
            end else begin
              yy_b <= yy_b - 7'd1;
            end
          end else begin
            mon_b <= mon_b - 7'd2;
          end
          state <= D_SUM;
        end
        D_SUM: begin
          // Century term 5*cc + cc/4 repeats every four centuries, so only cc mod 4
          acc   <= {4'd0, mon_mult[9:5]}
                 + {2'b00, day_b}
                 + {2'b00, yy_b}
                 + {4'd0, yy_b[6:2]}
                 + {5'd0, cc_mod, 2'b00}
                 + {7'd0, cc_mod};
          state <= D_MOD;
        end
        default: begin
          if (acc >= 9'd7) begin
            acc <= acc - 9'd7;
          end else begin
            state <= D_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/rtc_calendar.sv */
`timescale 1ns/100ps
`default_nettype none

module rtc_calendar #(
  parameter logic [31:0] tick_div = rtc_pkg::TICK_DIV_DEFAULT
) (
  input  logic               clkin,
  input  logic               rst,
  input  logic               run,
  input  logic               load_req,
  input  rtc_pkg::bcd_time_t load_time,
  input  rtc_pkg::bcd_date_t load_date,
  output logic               load_ack,
  output logic               busy,
  output logic               sec_pulse,
  output rtc_pkg::bcd_time_t snap_time,
  output rtc_pkg::bcd_date_t snap_date,
  output rtc_pkg::dow_t      snap_dow,
  rtc_dow_if.cal             dow_port
);

  rtc_pkg::cal_state_t state;
  logic [4:0]          st_code;
  logic [3:0]          dig_idx;
  logic [31:0]         presc;
  logic                tick;
  logic                tick_pend;
  logic                go;
  logic                start_r;
  logic                carry;
  logic                wrap;
  // Date in [55:24], time in [23:0], one digit per sequencer state
  logic [55:0]         now;
  rtc_pkg::bcd_digit_t dig_cur;
  rtc_pkg::bcd_digit_t dig_wrap;
  rtc_pkg::bcd_digit_t hour10;
  rtc_pkg::bcd_digit_t day10;
  rtc_pkg::bcd_digit_t mon1;
  rtc_pkg::bcd_digit_t mon10;
  rtc_pkg::bcd_digit_t year1;
  rtc_pkg::bcd_digit_t year10;
  logic [3:0]          mon_bin;
  logic [4:0]          yr_mod;
  logic                leap_feb;
  logic [7:0]          dim;
  rtc_pkg::bcd_digit_t last_day1;

  // Days in month as two BCD digits
  function automatic logic [7:0] month_days(input logic [3:0] mon);
    case (mon)
      4'd2:                    return 8'h28;
      4'd4, 4'd6, 4'd9, 4'd11: return 8'h30;
      default:                 return 8'h31;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Prescaler

  assign tick = run && (presc == tick_div - 32'd1);
  assign go   = tick || (tick_pend && run);

  always_ff @(posedge clkin) begin
    if (rst) begin
      presc <= '0;
    end else if (load_ack || tick) begin
      presc <= '0;
    end else if (run) begin
      presc <= presc + 32'd1;
    end
  end

  // Tick seen mid-sequence, served once back in IDLE
  always_ff @(posedge clkin) begin
    if (rst) begin
      tick_pend <= 1'b0;
    end else if (state == rtc_pkg::IDLE || !run) begin
      tick_pend <= 1'b0;
    end else if (tick) begin
      tick_pend <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Digit limits

  assign st_code = state;
  assign dig_idx = st_code[3:0];
  assign dig_cur = now[{dig_idx, 2'b00} +: 4];

  assign hour10 = now[23:20];
  assign day10  = now[31:28];
  assign mon1   = now[35:32];
  assign mon10  = now[39:36];
  assign year1  = now[43:40];
  assign year10 = now[47:44];

  assign mon_bin = mon10[0] ? mon1 + 4'd10 : mon1;
  // Two-digit year mod 4 is (2*tens + ones) mod 4
  assign yr_mod    = {3'b000, year10[0], 1'b0} + {1'b0, year1};
  assign leap_feb  = (mon_bin == 4'd2) && (yr_mod[1:0] == 2'b00);
  assign dim       = month_days(mon_bin);
  assign last_day1 = dim[3:0] + {3'b000, leap_feb};

  always_comb begin
    case (state)
      rtc_pkg::SEC10,
      rtc_pkg::MIN10:  wrap = (dig_cur == 4'd5);
      rtc_pkg::HOUR1:  wrap = (dig_cur == 4'd9) || (hour10 == 4'd2 && dig_cur == 4'd3);
      rtc_pkg::HOUR10: wrap = (dig_cur == 4'd2);
      rtc_pkg::DAY1:   wrap = (dig_cur == 4'd9) || (day10 == dim[7:4] && dig_cur == last_day1);
      rtc_pkg::DAY10:  wrap = (dig_cur == dim[7:4]);
      rtc_pkg::MON1:   wrap = (dig_cur == 4'd9) || (mon10 == 4'd1 && dig_cur == 4'd2);
      rtc_pkg::MON10:  wrap = (dig_cur == 4'd1);
      default:         wrap = (dig_cur == 4'd9);
    endcase
  end

  // December rolls to 01, everything else to 0
  assign dig_wrap = (state == rtc_pkg::MON1 && mon10 == 4'd1) ? 4'd1 : 4'd0;

  ////////////////////////////////////////////////////////////
  // Sequencer and snapshot

  assign load_ack       = (state == rtc_pkg::IDLE) && load_req;
  assign busy           = (state != rtc_pkg::IDLE);
  assign sec_pulse      = (state == rtc_pkg::LATCH);
  assign dow_port.start = start_r;
  assign dow_port.date  = now[55:24];

  always_ff @(posedge clkin) begin
    if (rst) begin
      state     <= rtc_pkg::IDLE;
      start_r   <= 1'b0;
      carry     <= 1'b0;
      now       <= {32'h2000_0101, 24'h00_0000};
      snap_time <= '0;
      snap_date <= 32'h2000_0101;
      snap_dow  <= 3'd6;
    end else begin
      start_r <= 1'b0;
      case (state)
        rtc_pkg::IDLE: begin
          if (load_req) begin
            now     <= {load_date, load_time};
            start_r <= 1'b1;
            state   <= rtc_pkg::DOW_WAIT;
          end else if (go) begin
            carry <= 1'b1;
            state <= rtc_pkg::SEC1;
          end
        end
        rtc_pkg::DOW_WAIT: begin
          if (dow_port.done) begin
            snap_time <= now[23:0];
            snap_date <= now[55:24];
            snap_dow  <= dow_port.wday;
            state     <= rtc_pkg::LATCH;
          end
        end
        rtc_pkg::LATCH: begin
          state <= rtc_pkg::IDLE;
        end
        default: begin
          if (carry) begin
            if (wrap) begin
              now[{dig_idx, 2'b00} +: 4] <= dig_wrap;
              // Day rollover restarts at 01
              if (state == rtc_pkg::DAY10) begin
                now[27:24] <= 4'd1;
              end
            end else begin
              now[{dig_idx, 2'b00} +: 4] <= dig_cur + 4'd1;
              carry <= 1'b0;
            end
          end
          start_r <= (state == rtc_pkg::YEAR1000);
          state   <= rtc_pkg::cal_state_t'(st_code + 5'd1);
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/rtc_axil_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module rtc_axil_regs (
  input  logic                clkin,
  input  logic                rst,
  input  logic                awvalid,
  input  rtc_pkg::axil_addr_t awaddr,
  output logic                awready,
  input  logic                wvalid,
  input  logic [31:0]         wdata,
  input  logic [3:0]          wstrb,
  output logic                wready,
  output logic                bvalid,
  output logic [1:0]          bresp,
  input  logic                bready,
  input  logic                arvalid,
  input  rtc_pkg::axil_addr_t araddr,
  output logic                arready,
  output logic                rvalid,
  output logic [31:0]         rdata,
  output logic [1:0]          rresp,
  input  logic                rready,
  output logic                run,
  output logic                load_req,
  output rtc_pkg::bcd_time_t  load_time,
  output rtc_pkg::bcd_date_t  load_date,
  input  logic                load_ack,
  input  logic                busy,
  input  rtc_pkg::bcd_time_t  snap_time,
  input  rtc_pkg::bcd_date_t  snap_date,
  input  rtc_pkg::dow_t       snap_dow
);

  logic        wr_go;
  logic        rd_go;
  logic [31:0] rd_word;

  ////////////////////////////////////////////////////////////
  // Write channel

  // AW and W taken together; a pending load holds off the next write
  assign wr_go   = awvalid && wvalid && !bvalid && !load_req;
  assign awready = wr_go;
  assign wready  = wr_go;
  assign bresp   = 2'b00;

  always_ff @(posedge clkin) begin
    if (rst) begin
      bvalid <= 1'b0;
    end else if (wr_go) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // Staging registers
  always_ff @(posedge clkin) begin
    if (wr_go && awaddr == rtc_pkg::REG_TIME) begin
      for (int b = 0; b < 3; b++) begin
        if (wstrb[b]) begin
          load_time[8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
    if (wr_go && awaddr == rtc_pkg::REG_DATE) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          load_date[8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // Control register
  always_ff @(posedge clkin) begin
    if (rst) begin
      run      <= 1'b0;
      load_req <= 1'b0;
    end else begin
      if (load_ack) begin
        load_req <= 1'b0;
      end
      if (wr_go && awaddr == rtc_pkg::REG_CTRL && wstrb[0]) begin
        run <= wdata[rtc_pkg::CTRL_RUN_BIT];
        if (wdata[rtc_pkg::CTRL_LOAD_BIT]) begin
          load_req <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read channel

  assign arready = !rvalid;
  assign rd_go   = arvalid && arready;
  assign rresp   = 2'b00;

  always_comb begin
    rd_word = '0;
    case (araddr)
      rtc_pkg::REG_TIME: rd_word = {8'h00, snap_time};
      rtc_pkg::REG_DATE: rd_word = snap_date;
      rtc_pkg::REG_DOW:  rd_word = {29'd0, snap_dow};
      rtc_pkg::REG_CTRL: begin
        rd_word[rtc_pkg::CTRL_RUN_BIT]  = run;
        // Counts as busy from the load write on
        rd_word[rtc_pkg::CTRL_BUSY_BIT] = busy || load_req;
      end
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clkin) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (rd_go) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clkin) begin
    if (rd_go) begin
      rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

/* rtl/rtc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rtc_top #(
  parameter logic [31:0] tick_div = rtc_pkg::TICK_DIV_DEFAULT
) (
  input  logic                clkin,
  input  logic                rst,
  input  logic                awvalid,
  input  rtc_pkg::axil_addr_t awaddr,
  output logic                awready,
  input  logic                wvalid,
  input  logic [31:0]         wdata,
  input  logic [3:0]          wstrb,
  output logic                wready,
  output logic                bvalid,
  output logic [1:0]          bresp,
  input  logic                bready,
  input  logic                arvalid,
  input  rtc_pkg::axil_addr_t araddr,
  output logic                arready,
  output logic                rvalid,
  output logic [31:0]         rdata,
  output logic [1:0]          rresp,
  input  logic                rready,
  output logic                sec_pulse
);

  logic               run;
  logic               load_req;
  logic               load_ack;
  logic               busy;
  rtc_pkg::bcd_time_t load_time;
  rtc_pkg::bcd_date_t load_date;
  rtc_pkg::bcd_time_t snap_time;
  rtc_pkg::bcd_date_t snap_date;
  rtc_pkg::dow_t      snap_dow;

  rtc_dow_if dow_bus ();

  rtc_axil_regs u_regs (
    .clkin     (clkin),
    .rst       (rst),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awready   (awready),
    .wvalid    (wvalid),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wready    (wready),
    .bvalid    (bvalid),
    .bresp     (bresp),
    .bready    (bready),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arready   (arready),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .rresp     (rresp),
    .rready    (rready),
    .run       (run),
    .load_req  (load_req),
    .load_time (load_time),
    .load_date (load_date),
    .load_ack  (load_ack),
    .busy      (busy),
    .snap_time (snap_time),
    .snap_date (snap_date),
    .snap_dow  (snap_dow)
  );

  rtc_calendar #(
    .tick_div (tick_div)
  ) u_calendar (
    .clkin     (clkin),
    .rst       (rst),
    .run       (run),
    .load_req  (load_req),
    .load_time (load_time),
    .load_date (load_date),
    .load_ack  (load_ack),
    .busy      (busy),
    .sec_pulse (sec_pulse),
    .snap_time (snap_time),
    .snap_date (snap_date),
    .snap_dow  (snap_dow),
    .dow_port  (dow_bus.cal)
  );

  rtc_dow u_dow (
    .clkin (clkin),
    .rst   (rst),
    .port  (dow_bus.dow)
  );

endmodule

`default_nettype wire

/* dv/rtc_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module rtc_clkgen (
  output logic clkin,
  output logic rst
);

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 8;

  initial begin
    clkin = 1'b0;
    forever #(HALF_PERIOD) clkin = ~clkin;
  end

  // Released on a falling edge so the DUT sees a clean sync release
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clkin);
    @(negedge clkin);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* dv/rtc_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rtc_tb;

  localparam logic [31:0] TICK_DIV    = 32'd64;
  localparam int          NUM_CASES   = 7;
  localparam int          WAIT_LIMIT  = 100;
  localparam int          POLL_LIMIT  = 60;
  localparam int          PULSE_LIMIT = 3 * 64;
  localparam logic [31:0] CTRL_RUN    = 32'd1 << rtc_pkg::CTRL_RUN_BIT;
  localparam logic [31:0] CTRL_LOAD   = 32'd1 << rtc_pkg::CTRL_LOAD_BIT;

  logic        clkin;
  logic        rst;
  logic        awvalid;
  logic [3:0]  awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wready;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        bready;
  logic        arvalid;
  logic [3:0]  araddr;
  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rready;
  logic        sec_pulse;

  string       cur_test;
  string       case_name [NUM_CASES];
  logic [23:0] case_time [NUM_CASES];
  logic [31:0] case_date [NUM_CASES];
  int          case_secs [NUM_CASES];

  rtc_clkgen clkgen (
    .clkin (clkin),
    .rst   (rst)
  );

  rtc_top #(
    .tick_div (TICK_DIV)
  ) UUT (
    .clkin     (clkin),
    .rst       (rst),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awready   (awready),
    .wvalid    (wvalid),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wready    (wready),
    .bvalid    (bvalid),
    .bresp     (bresp),
    .bready    (bready),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arready   (arready),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .rresp     (rresp),
    .rready    (rready),
    .sec_pulse (sec_pulse)
  );

  ////////////////////////////////////////////////////////////
  // Error reporting

  task automatic abort_run(input string what);
    $display("Error in %s: %s", cur_test, what);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %h, actual %h", cur_test, what, expected, actual);
      $display("Finished with errors");
      $fatal(1, "first mismatch, run stopped");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Calendar model

  function automatic int bcd_to_int(input logic [7:0] b);
    return int'(b[7:4]) * 10 + int'(b[3:0]);
  endfunction

  function automatic logic [7:0] int_to_bcd(input int v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  // Leap year on every multiple of 4 with no century rule
  function automatic int days_in_month(input int mo, input int yy);
    case (mo)
      2:             return (yy % 4 == 0) ? 29 : 28;
      4, 6, 9, 11:   return 30;
      default:       return 31;
    endcase
  endfunction

  // Days counted from 2000-01-01 which was a Saturday
  function automatic int day_of_week(input logic [31:0] d);
    int yy;
    int mo;
    int days;
    int y;
    int m;
    yy   = bcd_to_int(d[31:24]) * 100 + bcd_to_int(d[23:16]);
    mo   = bcd_to_int(d[15:8]);
    days = bcd_to_int(d[7:0]) - 1;
    for (y = 2000; y < yy; y++) begin
      days = days + ((y % 4 == 0) ? 366 : 365);
    end
    for (m = 1; m < mo; m++) begin
      days = days + days_in_month(m, yy);
    end
    return (6 + days) % 7;
  endfunction

  task automatic next_second(inout logic [23:0] t, inout logic [31:0] d);
    int hh;
    int mm;
    int ss;
    int yy;
    int mo;
    int dd;
    hh = bcd_to_int(t[23:16]);
    mm = bcd_to_int(t[15:8]);
    ss = bcd_to_int(t[7:0]) + 1;
    yy = bcd_to_int(d[31:24]) * 100 + bcd_to_int(d[23:16]);
    mo = bcd_to_int(d[15:8]);
    dd = bcd_to_int(d[7:0]);
    if (ss == 60) begin
      ss = 0;
      mm++;
    end
    if (mm == 60) begin
      mm = 0;
      hh++;
    end
    if (hh == 24) begin
      hh = 0;
      dd++;
    end
    if (dd > days_in_month(mo, yy)) begin
      dd = 1;
      mo++;
    end
    if (mo == 13) begin
      mo = 1;
      yy++;
    end
    t = {int_to_bcd(hh), int_to_bcd(mm), int_to_bcd(ss)};
    d = {int_to_bcd(yy / 100), int_to_bcd(yy % 100), int_to_bcd(mo), int_to_bcd(dd)};
  endtask

  ////////////////////////////////////////////////////////////
  // Bus and wait tasks

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int waited;
    @(negedge clkin);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    bready  = 1'b1;
    waited  = 0;
    // AW and W go on the edge where both readies are high
    @(posedge clkin);
    while (!(awready && wready)) begin
      if (waited == WAIT_LIMIT) abort_run("write was not accepted in time");
      waited++;
      @(posedge clkin);
    end
    @(negedge clkin);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check_equal("bvalid", 32'd1, {31'd0, bvalid});
    check_equal("bresp", 32'd0, {30'd0, bresp});
    @(negedge clkin);
    check_equal("bvalid after bready", 32'd0, {31'd0, bvalid});
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
    int waited;
    @(negedge clkin);
    arvalid = 1'b1;
    araddr  = addr;
    waited  = 0;
    @(posedge clkin);
    while (!arready) begin
      if (waited == WAIT_LIMIT) abort_run("read address was not accepted in time");
      waited++;
      @(posedge clkin);
    end
    @(negedge clkin);
    arvalid = 1'b0;
    // One cycle after the AR handshake
    check_equal("rvalid", 32'd1, {31'd0, rvalid});
    data = rdata;
    check_equal("rresp", 32'd0, {30'd0, rresp});
    rready = 1'b1;
    @(negedge clkin);
    rready = 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] ctrl;
    int          polls;
    polls = 0;
    axil_read(rtc_pkg::REG_CTRL, ctrl);
    while (ctrl[rtc_pkg::CTRL_BUSY_BIT]) begin
      if (polls == POLL_LIMIT) abort_run("busy did not clear after load");
      polls++;
      axil_read(rtc_pkg::REG_CTRL, ctrl);
    end
  endtask

  task automatic wait_sec_pulse();
    int waited;
    waited = 0;
    @(negedge clkin);
    while (!sec_pulse) begin
      if (waited == 2 * PULSE_LIMIT) abort_run("sec_pulse never came");
      waited++;
      @(negedge clkin);
    end
  endtask

  task automatic check_snapshot(input logic [23:0] t, input logic [31:0] d);
    logic [31:0] rd;
    axil_read(rtc_pkg::REG_TIME, rd);
    check_equal("time", {8'h00, t}, rd);
    axil_read(rtc_pkg::REG_DATE, rd);
    check_equal("date", d, rd);
    axil_read(rtc_pkg::REG_DOW, rd);
    check_equal("day of week", day_of_week(d), rd);
  endtask

  task automatic add_case(input int idx, input string name, input logic [23:0] t,
                          input logic [31:0] d, input int secs);
    case_name[idx] = name;
    case_time[idx] = t;
    case_date[idx] = d;
    case_secs[idx] = secs;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    logic [23:0] exp_time;
    logic [31:0] exp_date;
    logic [31:0] rd;
    int          waited;
    int          i;
    int          s;

    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    cur_test    = "reset";

    add_case(0, "load_only",   24'h10_22_33, 32'h2031_0714, 0);
    add_case(1, "midnight",    24'h23_59_58, 32'h2024_0315, 3);
    add_case(2, "apr_30",      24'h23_59_59, 32'h2023_0430, 1);
    add_case(3, "feb_28_2023", 24'h23_59_59, 32'h2023_0228, 1);
    add_case(4, "feb_28_2024", 24'h23_59_59, 32'h2024_0228, 1);
    add_case(5, "feb_29_2024", 24'h23_59_59, 32'h2024_0229, 1);
    add_case(6, "century",     24'h23_59_59, 32'h2099_1231, 1);

    waited = 0;
    @(posedge clkin);
    while (rst) begin
      if (waited == 20) abort_run("reset was never released");
      waited++;
      @(posedge clkin);
    end
    @(negedge clkin);
    check_equal("sec_pulse", 32'd0, {31'd0, sec_pulse});
    check_equal("bvalid", 32'd0, {31'd0, bvalid});
    check_equal("rvalid", 32'd0, {31'd0, rvalid});
    check_snapshot(24'h00_00_00, 32'h2000_0101);
    axil_read(rtc_pkg::REG_CTRL, rd);
    check_equal("ctrl", 32'd0, rd);

    for (i = 0; i < NUM_CASES; i++) begin
      cur_test = case_name[i];
      exp_time = case_time[i];
      exp_date = case_date[i];
      axil_write(rtc_pkg::REG_TIME, {8'h00, exp_time}, 4'hF);
      axil_write(rtc_pkg::REG_DATE, exp_date, 4'hF);
      // Load with run low, so nothing advances
      axil_write(rtc_pkg::REG_CTRL, CTRL_LOAD, 4'h1);
      wait_idle();
      check_snapshot(exp_time, exp_date);
      if (case_secs[i] > 0) begin
        axil_write(rtc_pkg::REG_CTRL, CTRL_RUN, 4'h1);
        for (s = 0; s < case_secs[i]; s++) begin
          wait_sec_pulse();
          next_second(exp_time, exp_date);
          check_snapshot(exp_time, exp_date);
        end
        axil_write(rtc_pkg::REG_CTRL, 32'd0, 4'h1);
      end
    end

    // Run one more second, then stop and watch
    cur_test = "stop";
    axil_write(rtc_pkg::REG_CTRL, CTRL_RUN, 4'h1);
    wait_sec_pulse();
    next_second(exp_time, exp_date);
    check_snapshot(exp_time, exp_date);
    axil_write(rtc_pkg::REG_CTRL, 32'd0, 4'h1);
    axil_read(rtc_pkg::REG_CTRL, rd);
    check_equal("ctrl", 32'd0, rd);
    for (waited = 0; waited < PULSE_LIMIT; waited++) begin
      @(negedge clkin);
      if (sec_pulse) abort_run("sec_pulse seen while run is cleared");
    end
    check_snapshot(exp_time, exp_date);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
rtl/rtc_pkg.sv
rtl/rtc_dow_if.sv
rtl/rtc_dow.sv
rtl/rtc_calendar.sv
rtl/rtc_axil_regs.sv
rtl/rtc_top.sv
dv/rtc_clkgen.sv
dv/rtc_tb.sv

/* Makefile */
SIM := obj_dir/rtc_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build rtc_tb with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f build.f --top-module rtc_tb -Mdir obj_dir -o rtc_sim
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Finished with errors" sim.log; then \
	  echo "Simulation failed"; exit 1; \
	fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
